// File: tb.f
+incdir+tb
logic/pixelPkg.sv
logic/regPkg.sv
logic/lineDelay.sv
logic/lineBlendFilter.sv
logic/pickerOverlay.sv
logic/apbRegs.sv
logic/videoOverlayTop.sv
tb/videoOverlay_properties.sv
tb/videoOverlayTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the videoOverlay testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module videoOverlayTb -f tb.f -Mdir obj_dir
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/VvideoOverlayTb
simStatus=$?
if [ $simStatus -ne 0 ]; then
    echo "Simulation failed with status $simStatus"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: tb/videoOverlayTasks.svh
// Tasks for videoOverlayTb; inputs change on the falling edge, combinational outputs read 2 ns later

// ============================================================================
// Compare tasks
// ============================================================================

task automatic compareRgb(input string testName, input rgbPixel expected, input rgbPixel actual);
    if (actual !== expected) begin
        abortRun($sformatf("mismatch %s: expected %h, actual %h", testName, expected, actual));
    end
endtask

task automatic compareYcc(input string testName, input yccSample expected,
                          input yccSample actual);
    if (actual !== expected) begin
        abortRun($sformatf("mismatch %s: expected %h, actual %h", testName, expected, actual));
    end
endtask

task automatic compareData(input string testName, input apbData expected, input apbData actual);
    if (actual !== expected) begin
        abortRun($sformatf("mismatch %s: expected %h, actual %h", testName, expected, actual));
    end
endtask

task automatic compareBit(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
        abortRun($sformatf("mismatch %s: expected %b, actual %b", testName, expected, actual));
    end
endtask

// ============================================================================
// APB driver
// ============================================================================

// Setup phase, access phase, then back to idle
task automatic apbTransfer(input logic write, input apbAddr addr, input apbData wdata,
                           output apbData rdata, output logic err);
    @(negedge CLOCK_50);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge CLOCK_50);
    penable = 1'b1;
    #2;
    rdata = prdata;
    err   = pslverr;
    // Zero wait states, so the access phase always completes
    compareBit("apb pready", 1'b1, pready);
    @(negedge CLOCK_50);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic writeReg(input string testName, input apbAddr addr, input apbData data,
                        input logic expectErr);
    apbData rdata;
    logic   err;
    apbTransfer(1'b1, addr, data, rdata, err);
    compareBit({testName, " pslverr"}, expectErr, err);
endtask

task automatic checkReg(input string testName, input apbAddr addr, input apbData expected);
    apbData rdata;
    logic   err;
    apbTransfer(1'b0, addr, '0, rdata, err);
    compareBit({testName, " pslverr"}, 1'b0, err);
    compareData(testName, expected, rdata);
endtask

// Y in 24..16, X in 9..0
function automatic apbData posWord(input coordX x, input coordY y);
    return (apbData'(y) << 16) | apbData'(x);
endfunction

// ============================================================================
// Reference model helpers
// ============================================================================

// Blend of one request against the recorded history, then records it
function automatic yccSample predictBlend(input yccSample cur);
    yccSample one;
    yccSample two;
    yccSample result;
    int       depth;
    int       farV;
    int       midV;
    int       curV;
    depth = requestHistory.size();
    one = (depth >= lineLength) ? requestHistory[depth - lineLength] : '0;
    two = (depth >= 2 * lineLength) ? requestHistory[depth - 2 * lineLength] : '0;
    // Each byte on its own
    for (int b = 0; b < 2; b++) begin
        farV = int'(two[b * 8 +: 8]);
        midV = int'(one[b * 8 +: 8]);
        curV = int'(cur[b * 8 +: 8]);
        result[b * 8 +: 8] = 8'((farV + curV) / 4 + midV / 2);
    end
    requestHistory.push_back(cur);
    return result;
endfunction

task automatic checkBlendResult(input logic pending, input yccSample expected);
    compareBit("blend valid", pending, blendValid);
    if (pending) begin
        compareYcc("blend data", expected, blendedYcc);
    end
endtask

// A pending tick moves at once, then one move per tick
task automatic holdKey(input logic down, input int moves);
    @(negedge CLOCK_50);
    if (down) begin
        moveDownN = 1'b0;
    end else begin
        moveRightN = 1'b0;
    end
    repeat (moveTickCycles * (moves - 1) + 1) @(negedge CLOCK_50);
    moveDownN  = 1'b1;
    moveRightN = 1'b1;
    // Let a fresh tick become pending
    repeat (moveTickCycles) @(negedge CLOCK_50);
endtask

// Drives one raster position and checks videoOut a cycle later
task automatic checkPixel(input string testName, input coordX x, input coordY y,
                          input logic frameExp, input logic enable, input logic background);
    rgbPixel camera;
    bgPixel  bg;
    rgbPixel expected;
    camera = rgbPixel'($random(seed));
    bg     = bgPixel'($random(seed));
    if (enable && frameExp) begin
        expected = '0;
    end else if (background) begin
        expected = {bg[14:10], 3'b000, bg[9:5], 3'b000, bg[4:0], 3'b000};
    end else begin
        expected = camera;
    end
    @(negedge CLOCK_50);
    pixelX          = x;
    pixelY          = y;
    cameraPixel     = camera;
    backgroundPixel = bg;
    @(negedge CLOCK_50);
    compareRgb(testName, expected, videoOut);
endtask

task automatic captureAt(input rgbPixel colour);
    @(negedge CLOCK_50);
    pixelX      = curX;
    pixelY      = curY;
    cameraPixel = colour;
    captureN    = 1'b0;
    @(negedge CLOCK_50);
    captureN = 1'b1;
endtask

// ============================================================================
// Directed tests
// ============================================================================

task automatic testApbRegisters();
    apbData rdata;
    logic   err;
    checkReg("ctrl after reset", ctrlAddr, '0);
    checkReg("pos after reset", posAddr, posWord(curX, curY));
    checkReg("light after reset", lightAddr, '0);
    checkReg("dark after reset", darkAddr, '0);
    writeReg("ctrl write", ctrlAddr, 32'h5, 1'b0);
    checkReg("ctrl readback", ctrlAddr, 32'h5);
    // Read-only and unmapped addresses
    writeReg("pos write", posAddr, 32'h1234, 1'b1);
    apbTransfer(1'b0, 4'h2, '0, rdata, err);
    compareBit("unmapped pslverr", 1'b1, err);
    writeReg("ctrl clear", ctrlAddr, '0, 1'b0);
endtask

task automatic testFieldGating();
    for (int row = 10; row < 12; row++) begin
        @(negedge CLOCK_50);
        pixelY        = coordY'(row);
        pixelRequest  = 1'b1;
        oddFieldData  = yccSample'($random(seed));
        evenFieldData = yccSample'($random(seed));
        void'(predictBlend(((row % 2) == 1) ? evenFieldData : oddFieldData));
        #2;
        compareBit("odd read", (row % 2) == 0, oddFieldRead);
        compareBit("even read", (row % 2) == 1, evenFieldRead);
        @(negedge CLOCK_50);
        pixelRequest = 1'b0;
        #2;
        compareBit("odd read idle", 1'b0, oddFieldRead);
        compareBit("even read idle", 1'b0, evenFieldRead);
    end
endtask

task automatic testLineBlend();
    logic     request;
    logic     pending;
    yccSample expected;
    int       sent;
    pending  = 1'b0;
    expected = '0;
    for (int line = 0; line < 4; line++) begin
        sent = 0;
        while (sent < lineLength) begin
            @(negedge CLOCK_50);
            checkBlendResult(pending, expected);
            // About one cycle in four has no request
            request       = ($random(seed) & 3) != 0;
            pixelY        = coordY'(line);
            pixelRequest  = request;
            oddFieldData  = yccSample'($random(seed));
            evenFieldData = yccSample'($random(seed));
            pending       = request;
            if (request) begin
                expected = predictBlend(pixelY[0] ? evenFieldData : oddFieldData);
                sent++;
            end
        end
    end
    @(negedge CLOCK_50);
    checkBlendResult(pending, expected);
    pixelRequest = 1'b0;
endtask

task automatic testMovement();
    writeReg("move enable", ctrlAddr, 32'h1, 1'b0);
    holdKey(1'b1, 3);
    curY = coordY'(curY + 3);
    checkReg("move down", posAddr, posWord(curX, curY));
    holdKey(1'b0, 637 - int'(curX));
    curX = coordX'(637);
    checkReg("move right", posAddr, posWord(curX, curY));
    // 638, 639, then wraps through 0
    holdKey(1'b0, 5);
    curX = coordX'((637 + 5) % screenWidth);
    checkReg("move wrap", posAddr, posWord(curX, curY));
endtask

task automatic testFrameSource();
    apbData ctrlWords [3];
    logic   enable;
    logic   background;
    ctrlWords[0] = 32'h1;
    ctrlWords[1] = 32'h5;
    ctrlWords[2] = 32'h4;
    foreach (ctrlWords[i]) begin
        enable     = ctrlWords[i][ctrlPickerBit];
        background = ctrlWords[i][ctrlBackgroundBit];
        writeReg("frame ctrl", ctrlAddr, ctrlWords[i], 1'b0);
        checkPixel("frame corner", curX, curY, 1'b1, enable, background);
        checkPixel("frame right edge", coordX'(curX + 9), coordY'(curY + 5), 1'b1,
                   enable, background);
        checkPixel("cursor inside", coordX'(curX + 4), coordY'(curY + 4), 1'b0,
                   enable, background);
        checkPixel("cursor outside", coordX'(curX + 20), coordY'(curY + 3), 1'b0,
                   enable, background);
    end
endtask

task automatic testCapture();
    rgbPixel lightExp;
    rgbPixel darkExp;
    lightExp = rgbPixel'($random(seed));
    darkExp  = rgbPixel'($random(seed));
    writeReg("capture light ctrl", ctrlAddr, 32'h1, 1'b0);
    captureAt(lightExp);
    checkReg("capture light", lightAddr, apbData'(lightExp));
    checkReg("dark untouched", darkAddr, '0);
    writeReg("capture dark ctrl", ctrlAddr, 32'h3, 1'b0);
    captureAt(darkExp);
    checkReg("capture dark", darkAddr, apbData'(darkExp));
    checkReg("light untouched", lightAddr, apbData'(lightExp));
endtask

// File: tb/videoOverlayTb.sv
// Testbench for videoOverlayTop with 8-sample lines and a 4-cycle move tick to keep runs short

`timescale 1ns/1ps

module videoOverlayTb;
    import pixelPkg::*;
    import regPkg::*;

    localparam int lineLength     = 8;
    localparam int moveTickCycles = 4;
    localparam int clockPeriod    = 20;

    // ========================================================================
    // One cycle budget per directed test
    // ========================================================================

    localparam int resetBudget   = 4;
    localparam int apbBudget     = 40;
    localparam int gatingBudget  = 10;
    localparam int blendBudget   = 4 * lineLength * 2 + 10;
    // 545 cursor moves in total, plus register reads
    localparam int moveBudget    = moveTickCycles * 545 + 60;
    localparam int frameBudget   = 40;
    localparam int captureBudget = 30;
    localparam int watchdogCycles = 2 * (resetBudget + apbBudget + gatingBudget +
                                         blendBudget + moveBudget + frameBudget +
                                         captureBudget);

    // DUT inputs
    logic     CLOCK_50;
    logic     rstN;
    logic     psel;
    logic     penable;
    logic     pwrite;
    apbAddr   paddr;
    apbData   pwdata;
    coordX    pixelX;
    coordY    pixelY;
    logic     pixelRequest;
    yccSample oddFieldData;
    yccSample evenFieldData;
    rgbPixel  cameraPixel;
    bgPixel   backgroundPixel;
    logic     moveDownN;
    logic     moveRightN;
    logic     captureN;

    // DUT outputs
    apbData   prdata;
    logic     pready;
    logic     pslverr;
    logic     oddFieldRead;
    logic     evenFieldRead;
    yccSample blendedYcc;
    logic     blendValid;
    rgbPixel  videoOut;

    // Stimulus seed
    int seed = 32'h35abd20a;

    // Every sample shifted into the line delays, oldest first
    yccSample requestHistory[$];

    // Expected cursor corner
    coordX curX;
    coordY curY;

    videoOverlayTop #(
        .lineLength    (lineLength),
        .moveTickCycles(moveTickCycles)
    ) DUT (
        .CLOCK_50       (CLOCK_50),
        .rstN           (rstN),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .pixelX         (pixelX),
        .pixelY         (pixelY),
        .pixelRequest   (pixelRequest),
        .oddFieldData   (oddFieldData),
        .evenFieldData  (evenFieldData),
        .oddFieldRead   (oddFieldRead),
        .evenFieldRead  (evenFieldRead),
        .blendedYcc     (blendedYcc),
        .blendValid     (blendValid),
        .cameraPixel    (cameraPixel),
        .backgroundPixel(backgroundPixel),
        .moveDownN      (moveDownN),
        .moveRightN     (moveRightN),
        .captureN       (captureN),
        .videoOut       (videoOut)
    );

    // Error line, then the verdict, then stop
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "videoOverlayTasks.svh"

    always #(clockPeriod / 2) CLOCK_50 = ~CLOCK_50;

    // Watchdog
    initial begin
        #(watchdogCycles * clockPeriod);
        abortRun("timeout: the directed tests did not finish within the cycle budget");
    end

    initial begin
        CLOCK_50        = 1'b0;
        rstN            = 1'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        pixelX          = '0;
        pixelY          = '0;
        pixelRequest    = 1'b0;
        oddFieldData    = '0;
        evenFieldData   = '0;
        cameraPixel     = '0;
        backgroundPixel = '0;
        // Keys are active low, so released
        moveDownN       = 1'b1;
        moveRightN      = 1'b1;
        captureN        = 1'b1;
        curX            = coordX'(cursorStartX);
        curY            = coordY'(cursorStartY);

        repeat (resetBudget) @(negedge CLOCK_50);
        rstN = 1'b1;

        testApbRegisters();
        testFieldGating();
        testLineBlend();
        testMovement();
        testFrameSource();
        testCapture();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: tb/videoOverlay_properties.sv
// Bound checks for apbRegs and lineBlendFilter; each bind ties the ports it has no signal for

`timescale 1ns/1ps

module videoOverlayProperties (
    input logic CLOCK_50,
    input logic rstN,
    input logic pready,
    input logic oddFieldRead,
    input logic evenFieldRead,
    input logic pixelRequest,
    input logic blendValid
);

    // No wait states ever
    readyHigh: assert property (@(posedge CLOCK_50) disable iff (!rstN) pready)
        else $error("pready went low");

    // One field fetched at a time
    singleFieldRead: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        !(oddFieldRead && evenFieldRead))
        else $error("odd and even field reads were high together");

    // Output register tracks the request one cycle late
    validFollowsRequest: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        blendValid == $past(pixelRequest))
        else $error("blendValid did not follow pixelRequest by one cycle");

endmodule

bind apbRegs videoOverlayProperties apbChecks (
    .CLOCK_50     (CLOCK_50),
    .rstN         (rstN),
    .pready       (pready),
    .oddFieldRead (1'b0),
    .evenFieldRead(1'b0),
    .pixelRequest (1'b0),
    .blendValid   (1'b0)
);

bind lineBlendFilter videoOverlayProperties blendChecks (
    .CLOCK_50     (CLOCK_50),
    .rstN         (rstN),
    .pready       (1'b1),
    .oddFieldRead (oddFieldRead),
    .evenFieldRead(evenFieldRead),
    .pixelRequest (pixelRequest),
    .blendValid   (blendValid)
);

// File: logic/videoOverlayTop.sv
// Single-clock top; raster position, request and all pixel sources come from outside

`timescale 1ns/1ps

module videoOverlayTop #(
    parameter int lineLength     = pixelPkg::screenWidth,
    parameter int moveTickCycles = 500000
) (
    input  logic               CLOCK_50,
    input  logic               rstN,
    // APB port
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  regPkg::apbAddr     paddr,
    input  regPkg::apbData     pwdata,
    output regPkg::apbData     prdata,
    output logic               pready,
    output logic               pslverr,
    // Raster and field stream
    input  pixelPkg::coordX    pixelX,
    input  pixelPkg::coordY    pixelY,
    input  logic               pixelRequest,
    input  pixelPkg::yccSample oddFieldData,
    input  pixelPkg::yccSample evenFieldData,
    output logic               oddFieldRead,
    output logic               evenFieldRead,
    output pixelPkg::yccSample blendedYcc,
    output logic               blendValid,
    // Pixel sources and keys
    input  pixelPkg::rgbPixel  cameraPixel,
    input  pixelPkg::bgPixel   backgroundPixel,
    input  logic               moveDownN,
    input  logic               moveRightN,
    input  logic               captureN,
    output pixelPkg::rgbPixel  videoOut
);
    import pixelPkg::*;

    // Between register block and overlay
    logic    pickerEnable;
    logic    captureDark;
    logic    showBackground;
    coordX   pickerX;
    coordY   pickerY;
    rgbPixel lightColour;
    rgbPixel darkColour;

    lineBlendFilter #(
        .lineLength(lineLength)
    ) blendFilter (
        .CLOCK_50     (CLOCK_50),
        .rstN         (rstN),
        .pixelY       (pixelY),
        .pixelRequest (pixelRequest),
        .oddFieldData (oddFieldData),
        .evenFieldData(evenFieldData),
        .oddFieldRead (oddFieldRead),
        .evenFieldRead(evenFieldRead),
        .blendedYcc   (blendedYcc),
        .blendValid   (blendValid)
    );

    pickerOverlay #(
        .moveTickCycles(moveTickCycles)
    ) overlay (
        .CLOCK_50       (CLOCK_50),
        .rstN           (rstN),
        .pixelX         (pixelX),
        .pixelY         (pixelY),
        .cameraPixel    (cameraPixel),
        .backgroundPixel(backgroundPixel),
        .moveDownN      (moveDownN),
        .moveRightN     (moveRightN),
        .captureN       (captureN),
        .pickerEnable   (pickerEnable),
        .captureDark    (captureDark),
        .showBackground (showBackground),
        .videoOut       (videoOut),
        .pickerX        (pickerX),
        .pickerY        (pickerY),
        .lightColour    (lightColour),
        .darkColour     (darkColour)
    );

    apbRegs regs (
        .CLOCK_50      (CLOCK_50),
        .rstN          (rstN),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .pickerEnable  (pickerEnable),
        .captureDark   (captureDark),
        .showBackground(showBackground),
        .pickerX       (pickerX),
        .pickerY       (pickerY),
        .lightColour   (lightColour),
        .darkColour    (darkColour)
    );

endmodule

// File: logic/apbRegs.sv
// APB slave without wait states; unmapped addresses read zero and raise pslverr

`timescale 1ns/1ps

module apbRegs (
    input  logic              CLOCK_50,
    input  logic              rstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  regPkg::apbAddr    paddr,
    input  regPkg::apbData    pwdata,
    output regPkg::apbData    prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              pickerEnable,
    output logic              captureDark,
    output logic              showBackground,
    input  pixelPkg::coordX   pickerX,
    input  pixelPkg::coordY   pickerY,
    input  pixelPkg::rgbPixel lightColour,
    input  pixelPkg::rgbPixel darkColour
);
    import regPkg::*;

    logic [2:0] ctrlReg;
    logic       accessPhase;
    logic       addrMapped;
    logic       ctrlWrite;

    assign accessPhase = psel && penable;
    assign addrMapped  = (paddr == ctrlAddr) || (paddr == posAddr) ||
                         (paddr == lightAddr) || (paddr == darkAddr);
    assign ctrlWrite   = accessPhase && pwrite && (paddr == ctrlAddr);

    // ========================================================================
    // Control register
    // ========================================================================

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            ctrlReg <= '0;
        end else if (ctrlWrite) begin
            ctrlReg[ctrlPickerBit]     <= pwdata[ctrlPickerBit];
            ctrlReg[ctrlDarkBit]       <= pwdata[ctrlDarkBit];
            ctrlReg[ctrlBackgroundBit] <= pwdata[ctrlBackgroundBit];
        end
    end

    assign pickerEnable   = ctrlReg[ctrlPickerBit];
    assign captureDark    = ctrlReg[ctrlDarkBit];
    assign showBackground = ctrlReg[ctrlBackgroundBit];

    // ========================================================================
    // Read mux and response
    // ========================================================================

    always_comb begin
        case (paddr)
            ctrlAddr:  prdata = {29'd0, ctrlReg};
            posAddr:   prdata = {7'd0, pickerY, 6'd0, pickerX};
            lightAddr: prdata = {8'd0, lightColour};
            darkAddr:  prdata = {8'd0, darkColour};
            default:   prdata = '0;
        endcase
    end

    // Never stalls
    assign pready = 1'b1;

    // Unmapped address, or write to a read-only register
    assign pslverr = accessPhase && (!addrMapped || (pwrite && (paddr != ctrlAddr)));

endmodule

// File: logic/pickerOverlay.sv
// Colour picker cursor; keys are active low and must be held across a move tick to move

`timescale 1ns/1ps

module pickerOverlay #(
    parameter int moveTickCycles = 500000
) (
    input  logic              CLOCK_50,
    input  logic              rstN,
    input  pixelPkg::coordX   pixelX,
    input  pixelPkg::coordY   pixelY,
    input  pixelPkg::rgbPixel cameraPixel,
    input  pixelPkg::bgPixel  backgroundPixel,
    input  logic              moveDownN,
    input  logic              moveRightN,
    input  logic              captureN,
    input  logic              pickerEnable,
    input  logic              captureDark,
    input  logic              showBackground,
    output pixelPkg::rgbPixel videoOut,
    output pixelPkg::coordX   pickerX,
    output pixelPkg::coordY   pickerY,
    output pixelPkg::rgbPixel lightColour,
    output pixelPkg::rgbPixel darkColour
);
    import pixelPkg::*;

    localparam int tickBits = $clog2(moveTickCycles + 1);

    logic [tickBits-1:0] tickCount;
    logic                tickHit;
    logic                moveFlag;
    logic                moveDown;
    logic                moveRight;
    logic                moveNow;
    logic                atCorner;
    logic                captureNow;
    coordX               relX;
    coordY               relY;
    logic                insideCursor;
    logic                onFrame;
    rgbPixel             expandedBg;
    rgbPixel             sourcePixel;

    // ========================================================================
    // Move tick
    // ========================================================================

    assign tickHit = (tickCount == tickBits'(moveTickCycles - 1));

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            tickCount <= '0;
            moveFlag  <= 1'b0;
        end else begin
            if (tickHit) begin
                tickCount <= '0;
            end else begin
                tickCount <= tickCount + 1'b1;
            end
            // New tick wins over consumption of the old one
            if (tickHit) begin
                moveFlag <= 1'b1;
            end else if (moveNow) begin
                moveFlag <= 1'b0;
            end
        end
    end

    // Down has priority over right
    assign moveDown  = pickerEnable && moveFlag && !moveDownN;
    assign moveRight = pickerEnable && moveFlag && moveDownN && !moveRightN;
    assign moveNow   = moveDown || moveRight;

    // ========================================================================
    // Cursor position
    // ========================================================================

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            pickerX <= coordX'(cursorStartX);
            pickerY <= coordY'(cursorStartY);
        end else if (moveDown) begin
            // Wrap after the last visible row
            pickerY <= (pickerY == coordY'(screenHeight - 1)) ? '0 : pickerY + 1'b1;
        end else if (moveRight) begin
            pickerX <= (pickerX == coordX'(screenWidth - 1)) ? '0 : pickerX + 1'b1;
        end
    end

    // ========================================================================
    // Colour capture
    // ========================================================================

    assign atCorner   = (pixelX == pickerX) && (pixelY == pickerY);
    assign captureNow = !moveNow && !captureN && atCorner;

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            lightColour <= '0;
            darkColour  <= '0;
        end else if (captureNow) begin
            if (captureDark) begin
                darkColour <= cameraPixel;
            end else begin
                lightColour <= cameraPixel;
            end
        end
    end

    // ========================================================================
    // Drawing
    // ========================================================================

    // Offset inside the cursor square
    // Negative offsets wrap to large values
    assign relX = pixelX - pickerX;
    assign relY = pixelY - pickerY;

    assign insideCursor = (relX < coordX'(cursorSize)) && (relY < coordY'(cursorSize));
    assign onFrame = insideCursor &&
                     ((relX < coordX'(frameWidth)) ||
                      (relX >= coordX'(cursorSize - frameWidth)) ||
                      (relY < coordY'(frameWidth)) ||
                      (relY >= coordY'(cursorSize - frameWidth)));

    // 5-bit channels to the top of each byte
    assign expandedBg = {backgroundPixel[14:10], 3'b000,
                         backgroundPixel[9:5],   3'b000,
                         backgroundPixel[4:0],   3'b000};
    assign sourcePixel = showBackground ? expandedBg : cameraPixel;

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            videoOut <= '0;
        end else if (pickerEnable && onFrame) begin
            videoOut <= '0;
        end else begin
            videoOut <= sourcePixel;
        end
    end

endmodule

// File: logic/lineBlendFilter.sv
// Vertical 1-2-1 style blend over three lines; only advances on pixelRequest, no back-pressure

`timescale 1ns/1ps

module lineBlendFilter #(
    parameter int lineLength = pixelPkg::screenWidth
) (
    input  logic               CLOCK_50,
    input  logic               rstN,
    input  pixelPkg::coordY    pixelY,
    input  logic               pixelRequest,
    input  pixelPkg::yccSample oddFieldData,
    input  pixelPkg::yccSample evenFieldData,
    output logic               oddFieldRead,
    output logic               evenFieldRead,
    output pixelPkg::yccSample blendedYcc,
    output logic               blendValid
);
    import pixelPkg::*;

    yccSample currentSample;
    yccSample oneLineBack;
    yccSample twoLinesBack;

    // Each byte gets (far + current) / 4 + mid / 2
    function automatic logic [7:0] blendByte(input logic [7:0] farByte,
                                             input logic [7:0] midByte,
                                             input logic [7:0] curByte);
        logic [8:0] outerSum;
        outerSum = {1'b0, farByte} + {1'b0, curByte};
        return {1'b0, outerSum[8:2]} + {1'b0, midByte[7:1]};
    endfunction

    // ========================================================================
    // Field select
    // ========================================================================

    // Even rows fetch from the odd field, odd rows from the even field
    assign oddFieldRead  = pixelY[0] ? 1'b0 : pixelRequest;
    assign evenFieldRead = pixelY[0] ? pixelRequest : 1'b0;
    assign currentSample = pixelY[0] ? evenFieldData : oddFieldData;

    // Two chained line delays
    lineDelay #(
        .lineLength(lineLength)
    ) firstDelay (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .shiftEnable(pixelRequest),
        .sampleIn   (currentSample),
        .sampleOut  (oneLineBack)
    );

    lineDelay #(
        .lineLength(lineLength)
    ) secondDelay (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .shiftEnable(pixelRequest),
        .sampleIn   (oneLineBack),
        .sampleOut  (twoLinesBack)
    );

    // ========================================================================
    // Blend output register
    // ========================================================================

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            blendValid <= 1'b0;
        end else begin
            blendValid <= pixelRequest;
        end
    end

    // Uses delay outputs before this request shifts them
    always_ff @(posedge CLOCK_50) begin
        if (pixelRequest) begin
            blendedYcc[15:8] <= blendByte(twoLinesBack[15:8], oneLineBack[15:8],
                                          currentSample[15:8]);
            blendedYcc[7:0]  <= blendByte(twoLinesBack[7:0], oneLineBack[7:0],
                                          currentSample[7:0]);
        end
    end

endmodule

// File: logic/lineDelay.sv
// Flop-based line delay; depth is lineLength samples, so large lines cost many registers

`timescale 1ns/1ps

module lineDelay #(
    parameter int lineLength = pixelPkg::screenWidth
) (
    input  logic               CLOCK_50,
    input  logic               rstN,
    input  logic               shiftEnable,
    input  pixelPkg::yccSample sampleIn,
    output pixelPkg::yccSample sampleOut
);
    import pixelPkg::*;

    // Stage 0 takes the new sample, last stage is the oldest
    yccSample stages [lineLength];

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            for (int i = 0; i < lineLength; i++) begin
                stages[i] <= '0;
            end
        end else if (shiftEnable) begin
            stages[0] <= sampleIn;
            for (int i = 1; i < lineLength; i++) begin
                stages[i] <= stages[i - 1];
            end
        end
    end

    // Sample that entered lineLength shifts ago
    assign sampleOut = stages[lineLength - 1];

endmodule

// File: logic/regPkg.sv
// APB register map; 4-bit word-aligned addresses, only ctrl is writable, others read-only

package regPkg;

    // Bus widths
    typedef logic [3:0]  apbAddr;
    typedef logic [31:0] apbData;

    // ========================================================================
    // Address map
    // ========================================================================

    // Read/write control bits
    localparam apbAddr ctrlAddr  = 4'h0;
    // Picker position with X in 9..0 and Y in 24..16
    localparam apbAddr posAddr   = 4'h4;
    // Captured colours as RGB in 23..0
    localparam apbAddr lightAddr = 4'h8;
    localparam apbAddr darkAddr  = 4'hC;

    // Control register bit positions
    localparam int ctrlPickerBit     = 0;
    localparam int ctrlDarkBit       = 1;
    localparam int ctrlBackgroundBit = 2;

endpackage

// File: logic/pixelPkg.sv
// Video types and cursor geometry; sizes assume a 640x480 raster with 8-bit colour channels

package pixelPkg;

    // ========================================================================
    // Pixel and sample types
    // ========================================================================

    // Camera and output pixel with red on top
    typedef logic [23:0] rgbPixel;

    // 5:5:5 background image pixel
    typedef logic [14:0] bgPixel;

    // YCbCr 4:2:2 sample with the Cr/Cb byte above the Y byte
    typedef logic [15:0] yccSample;

    // Raster coordinates
    typedef logic [9:0] coordX;
    typedef logic [8:0] coordY;

    // ========================================================================
    // Geometry
    // ========================================================================

    localparam int screenWidth  = 640;
    localparam int screenHeight = 480;

    // Cursor square and its black border
    localparam int cursorSize = 10;
    localparam int frameWidth = 2;

    // Where the cursor sits after reset
    localparam int cursorStartX = 100;
    localparam int cursorStartY = 100;

endpackage
